//--- logic/periph_pkg.sv
package periph_pkg;

	//**********************************************************************
	// Widths
	//**********************************************************************

	localparam int ADDR_W = 6;
	localparam int DATA_W = 32;
	localparam int PAD_W  = 16;
	localparam int SW_W   = 16;
	localparam int PB_W   = 5;

	// Debounced input groups
	typedef logic [SW_W-1:0] sw_t;
	typedef logic [PB_W-1:0] pb_t;

	//**********************************************************************
	// Host request and response
	//**********************************************************************

	// Word address, one request per strobe
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	//**********************************************************************
	// Address map
	//**********************************************************************

	// Block select in address bits 5:4, values 2 and 3 unmapped
	typedef enum logic [1:0] {
		BLK_GPIO = 2'd0,
		BLK_BTN  = 2'd1
	} blk_e;

	// Register index in address bits 1:0, index 3 unused
	typedef enum logic [1:0] {
		REG_DATA = 2'd0,
		REG_OE   = 2'd1,
		REG_IN   = 2'd2
	} reg_e;

	// Button port names for the same indices
	localparam reg_e REG_STATE = REG_DATA;
	localparam reg_e REG_MASK  = REG_OE;
	localparam reg_e REG_PEND  = REG_IN;

	function automatic blk_e addr_blk(input logic [ADDR_W-1:0] addr);
		return blk_e'(addr[5:4]);
	endfunction

	// Bits 3:2 not decoded, registers alias inside a block
	function automatic reg_e addr_reg(input logic [ADDR_W-1:0] addr);
		return reg_e'(addr[1:0]);
	endfunction

endpackage

//--- logic/input_debounce.sv
`timescale 1ns/10ps

module input_debounce #(
	parameter type payload_t = logic,
	parameter int  DB_CYCLES = 4
) (
	input  logic     clk,
	input  logic     i_rst,
	input  payload_t i_raw,
	output payload_t o_level
);

	localparam int CNT_W = $clog2(DB_CYCLES + 1);

	payload_t   raw_q;
	payload_t   prev_q;
	logic [CNT_W-1:0] stable_cnt;
	logic       stable;

	assign stable = (stable_cnt == CNT_W'(DB_CYCLES));

	// Sample raw group, keep last sample for change detection
	always_ff @(posedge clk) begin
		if (i_rst) begin
			raw_q  <= '0;
			prev_q <= '0;
		end else begin
			raw_q  <= i_raw;
			prev_q <= raw_q;
		end
	end

	// Any change in the group restarts the count
	always_ff @(posedge clk) begin
		if (i_rst) begin
			stable_cnt <= '0;
			o_level    <= '0;
		end else begin
			if (raw_q != prev_q) begin
				stable_cnt <= '0;
			end else if (!stable) begin
				stable_cnt <= stable_cnt + 1'b1;
			end
			if (stable) begin
				o_level <= prev_q;
			end
		end
	end

endmodule

//--- logic/gpio_port.sv
`timescale 1ns/10ps

module gpio_port
	import periph_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,

	// Register access from the decoder
	input  logic              i_stb,
	input  logic              i_we,
	input  reg_e              i_reg,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,

	// Pads and switches
	input  logic [PAD_W-1:0]  i_pad_in,
	input  sw_t               i_sw,
	output logic [PAD_W-1:0]  o_pad_out,
	output logic [PAD_W-1:0]  o_pad_oe
);

	logic [PAD_W-1:0] out_q;
	logic [PAD_W-1:0] oe_q;
	logic             wr_en;

	assign wr_en = i_stb && i_we;

	//**********************************************************************
	// LED output and output enable registers
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_rst) begin
			out_q <= '0;
			oe_q  <= '0;
		end else if (wr_en) begin
			case (i_reg)
				REG_DATA: out_q <= i_wdata[PAD_W-1:0];
				REG_OE:   oe_q  <= i_wdata[PAD_W-1:0];
				default: begin
					// REG_IN is read only
					out_q <= out_q;
				end
			endcase
		end
	end

	assign o_pad_out = out_q;
	assign o_pad_oe  = oe_q;

	//**********************************************************************
	// Read mux
	//**********************************************************************

	// Switches sit above the raw pads, like the split input word
	always_comb begin
		case (i_reg)
			REG_DATA: o_rdata = DATA_W'(out_q);
			REG_OE:   o_rdata = DATA_W'(oe_q);
			REG_IN:   o_rdata = DATA_W'({i_sw, i_pad_in});
			default:  o_rdata = '0;
		endcase
	end

endmodule

//--- logic/button_port.sv
`timescale 1ns/10ps

module button_port
	import periph_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,

	// Register access from the decoder
	input  logic              i_stb,
	input  logic              i_we,
	input  reg_e              i_reg,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,

	// Debounced buttons
	input  pb_t               i_btn,
	output logic              o_irq
);

	pb_t  btn_q;
	pb_t  pend_q;
	pb_t  mask_q;
	pb_t  rise;
	pb_t  pend_clr;
	logic wr_en;

	assign wr_en = i_stb && i_we;

	//**********************************************************************
	// Edge detect and pending bits
	//**********************************************************************

	assign rise = i_btn & ~btn_q;

	// Write one to clear
	assign pend_clr = (wr_en && i_reg == REG_PEND) ? i_wdata[PB_W-1:0] : '0;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			btn_q  <= '0;
			pend_q <= '0;
		end else begin
			btn_q  <= i_btn;
			// New edge wins over a clear in the same cycle
			pend_q <= (pend_q & ~pend_clr) | rise;
		end
	end

	//**********************************************************************
	// Mask and interrupt
	//**********************************************************************

	always_ff @(posedge clk) begin
		if (i_rst) begin
			mask_q <= '0;
		end else if (wr_en && i_reg == REG_MASK) begin
			mask_q <= i_wdata[PB_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_irq <= 1'b0;
		end else begin
			o_irq <= |(pend_q & mask_q);
		end
	end

	// Read mux
	always_comb begin
		case (i_reg)
			REG_STATE: o_rdata = DATA_W'(i_btn);
			REG_MASK:  o_rdata = DATA_W'(mask_q);
			REG_PEND:  o_rdata = DATA_W'(pend_q);
			default:   o_rdata = '0;
		endcase
	end

endmodule

//--- logic/bus_decode.sv
`timescale 1ns/10ps

module bus_decode
	import periph_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,

	// Host side
	input  logic              i_req_stb,
	input  bus_req_t          i_req,
	output logic              o_rsp_stb,
	output bus_rsp_t          o_rsp,

	// Port side
	output logic              o_gpio_stb,
	output logic              o_btn_stb,
	output logic              o_we,
	output reg_e              o_reg,
	output logic [DATA_W-1:0] o_wdata,
	input  logic [DATA_W-1:0] i_gpio_rdata,
	input  logic [DATA_W-1:0] i_btn_rdata
);

	blk_e              blk;
	logic [DATA_W-1:0] sel_rdata;
	logic              rd_hit;

	//**********************************************************************
	// Request steering
	//**********************************************************************

	assign blk = addr_blk(i_req.addr);

	// Only the addressed port sees the strobe
	assign o_gpio_stb = i_req_stb && (blk == BLK_GPIO);
	assign o_btn_stb  = i_req_stb && (blk == BLK_BTN);
	assign o_we       = i_req.we;
	assign o_reg      = addr_reg(i_req.addr);
	assign o_wdata    = i_req.wdata;

	// Unmapped blocks read zero
	always_comb begin
		case (blk)
			BLK_GPIO: sel_rdata = i_gpio_rdata;
			BLK_BTN:  sel_rdata = i_btn_rdata;
			default:  sel_rdata = '0;
		endcase
	end

	//**********************************************************************
	// Response register, one cycle after the request
	//**********************************************************************

	assign rd_hit = i_req_stb && !i_req.we;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_rsp_stb <= 1'b0;
		end else begin
			o_rsp_stb <= i_req_stb;
		end
	end

	// Writes and idle cycles carry zero
	always_ff @(posedge clk) begin
		o_rsp.rdata <= rd_hit ? sel_rdata : '0;
	end

endmodule

//--- logic/periph_core.sv
`timescale 1ns/10ps

module periph_core
	import periph_pkg::*;
#(
	parameter int DB_CYCLES = 4
) (
	input  logic             clk,
	input  logic             i_rst,

	// Host register port
	input  logic             i_req_stb,
	input  bus_req_t         i_req,
	output logic             o_rsp_stb,
	output bus_rsp_t         o_rsp,

	// Board I/O
	input  logic [PAD_W-1:0] i_pad_in,
	input  sw_t              i_sw_raw,
	input  pb_t              i_btn_raw,
	output logic [PAD_W-1:0] o_pad_out,
	output logic [PAD_W-1:0] o_pad_oe,
	output logic             o_irq
);

	logic              gpio_stb;
	logic              btn_stb;
	logic              we;
	reg_e              reg_idx;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] gpio_rdata;
	logic [DATA_W-1:0] btn_rdata;
	sw_t               sw_db;
	pb_t               pb_db;

	//**********************************************************************
	// Decoder
	//**********************************************************************

	bus_decode u_decode (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_req_stb    (i_req_stb),
		.i_req        (i_req),
		.o_rsp_stb    (o_rsp_stb),
		.o_rsp        (o_rsp),
		.o_gpio_stb   (gpio_stb),
		.o_btn_stb    (btn_stb),
		.o_we         (we),
		.o_reg        (reg_idx),
		.o_wdata      (wdata),
		.i_gpio_rdata (gpio_rdata),
		.i_btn_rdata  (btn_rdata)
	);

	//**********************************************************************
	// Ports and input filters
	//**********************************************************************

	gpio_port u_gpio (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_stb     (gpio_stb),
		.i_we      (we),
		.i_reg     (reg_idx),
		.i_wdata   (wdata),
		.o_rdata   (gpio_rdata),
		.i_pad_in  (i_pad_in),
		.i_sw      (sw_db),
		.o_pad_out (o_pad_out),
		.o_pad_oe  (o_pad_oe)
	);

	button_port u_btn (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_stb   (btn_stb),
		.i_we    (we),
		.i_reg   (reg_idx),
		.i_wdata (wdata),
		.o_rdata (btn_rdata),
		.i_btn   (pb_db),
		.o_irq   (o_irq)
	);

	// Same filter for both groups
	input_debounce #(
		.payload_t (sw_t),
		.DB_CYCLES (DB_CYCLES)
	) u_sw_db (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_raw   (i_sw_raw),
		.o_level (sw_db)
	);

	input_debounce #(
		.payload_t (pb_t),
		.DB_CYCLES (DB_CYCLES)
	) u_pb_db (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_raw   (i_btn_raw),
		.o_level (pb_db)
	);

endmodule

//--- include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Xorshift state and expected register values
logic [31:0]      rng_state;
logic [PAD_W-1:0] exp_out;
logic [PAD_W-1:0] exp_oe;
sw_t              exp_sw;
pb_t              exp_btn;
pb_t              exp_mask;
pb_t              exp_pend;

function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

task automatic model_reset();
	rng_state = 32'd93973;
	exp_out   = '0;
	exp_oe    = '0;
	exp_sw    = '0;
	exp_btn   = '0;
	exp_mask  = '0;
	exp_pend  = '0;
endtask

// Block in bits 5:4 and index in bits 1:0 with all other addresses reading zero
function automatic logic [31:0] expected_read(input logic [ADDR_W-1:0] addr);
	logic [31:0] data;
	data = 32'h0;
	if (addr[5:4] == 2'd0) begin
		case (addr[1:0])
			2'd0:    data = {16'h0000, exp_out};
			2'd1:    data = {16'h0000, exp_oe};
			2'd2:    data = {exp_sw, i_pad_in};
			default: data = 32'h0;
		endcase
	end else if (addr[5:4] == 2'd1) begin
		case (addr[1:0])
			2'd0:    data = {27'h0, exp_btn};
			2'd1:    data = {27'h0, exp_mask};
			2'd2:    data = {27'h0, exp_pend};
			default: data = 32'h0;
		endcase
	end
	return data;
endfunction

task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
	if (addr[5:4] == 2'd0 && addr[1:0] == 2'd0) exp_out = data[15:0];
	if (addr[5:4] == 2'd0 && addr[1:0] == 2'd1) exp_oe = data[15:0];
	if (addr[5:4] == 2'd1 && addr[1:0] == 2'd1) exp_mask = data[4:0];
	// Write one to clear
	if (addr[5:4] == 2'd1 && addr[1:0] == 2'd2) exp_pend = exp_pend & ~data[4:0];
endtask

task automatic check_irq();
	assert (o_irq == |(exp_pend & exp_mask))
		else value_mismatch("o_irq", 32'(o_irq), 32'(|(exp_pend & exp_mask)));
endtask

task automatic idle(input int cycles);
	for (int i = 0; i < cycles; i++) begin
		@(posedge clk);
		#1;
		assert (!o_rsp_stb) else protocol_error("response strobe seen without a request");
	end
endtask

// One request driven 1 ns after an edge and its response sampled after the next edge
task automatic access(input logic we, input logic [ADDR_W-1:0] addr,
	input logic [31:0] wdata);
	logic [31:0] exp;
	int          waited;
	exp = we ? 32'h0 : expected_read(addr);
	i_req.we    = we;
	i_req.addr  = addr;
	i_req.wdata = wdata;
	i_req_stb   = 1'b1;
	waited      = 0;
	do begin
		@(posedge clk);
		#1;
		i_req_stb = 1'b0;
		waited++;
	end while (!o_rsp_stb && waited < RSP_TIMEOUT);
	assert (o_rsp_stb) else protocol_error("timeout waiting for the response strobe");
	assert (waited == 1)
		else protocol_error("response strobe not one cycle after request");
	assert (o_rsp.rdata == exp) else value_mismatch("o_rsp.rdata", o_rsp.rdata, exp);
	if (we) begin
		model_write(addr, wdata);
	end
	assert (o_pad_out == exp_out)
		else value_mismatch("o_pad_out", 32'(o_pad_out), 32'(exp_out));
	assert (o_pad_oe == exp_oe)
		else value_mismatch("o_pad_oe", 32'(o_pad_oe), 32'(exp_oe));
endtask

`endif

//--- bench/tb_periph_core.sv
`timescale 1ns/10ps

module tb_periph_core
	import periph_pkg::*;
();

	localparam int DB_CYCLES   = 4;
	localparam int HOLD        = 3 * DB_CYCLES;
	localparam int RSP_TIMEOUT = 16;

	logic             clk;
	logic             i_rst;
	logic             i_req_stb;
	bus_req_t         i_req;
	logic             o_rsp_stb;
	bus_rsp_t         o_rsp;
	logic [PAD_W-1:0] i_pad_in;
	sw_t              i_sw_raw;
	pb_t              i_btn_raw;
	logic [PAD_W-1:0] o_pad_out;
	logic [PAD_W-1:0] o_pad_oe;
	logic             o_irq;
	int               errors;

	periph_core #(
		.DB_CYCLES (DB_CYCLES)
	) u_dut (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_req_stb (i_req_stb),
		.i_req     (i_req),
		.o_rsp_stb (o_rsp_stb),
		.o_rsp     (o_rsp),
		.i_pad_in  (i_pad_in),
		.i_sw_raw  (i_sw_raw),
		.i_btn_raw (i_btn_raw),
		.o_pad_out (o_pad_out),
		.o_pad_oe  (o_pad_oe),
		.o_irq     (o_irq)
	);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
		abort_run();
	endtask

	task automatic protocol_error(input string what);
		errors++;
		$display("%s", what);
		abort_run();
	endtask

	`include "tb_model.svh"

	//**********************************************************************
	// Test sequences
	//**********************************************************************

	task automatic check_reset_state();
		assert (o_pad_out == '0) else value_mismatch("o_pad_out", 32'(o_pad_out), 32'h0);
		assert (o_pad_oe == '0) else value_mismatch("o_pad_oe", 32'(o_pad_oe), 32'h0);
		check_irq();
		idle(4);
		access(1'b0, 6'h00, 32'h0);
		access(1'b0, 6'h01, 32'h0);
		access(1'b0, 6'h11, 32'h0);
		access(1'b0, 6'h12, 32'h0);
	endtask

	// Random GPIO traffic where r[4] makes the next request back to back
	task automatic gpio_random_test();
		logic [31:0] r;
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			access(r[0], {2'b00, r[3:2], 1'b0, r[1]}, next_rand());
			if (!r[4]) begin
				idle(int'(r[6:5]) + 1);
			end
		end
	endtask

	task automatic input_test();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			i_pad_in = r[15:0];
			i_sw_raw = r[31:16];
			idle(HOLD);
			exp_sw = r[31:16];
			access(1'b0, 6'h02, 32'h0);
			// Two cycle glitch must not reach the switch level at any time
			r = next_rand();
			i_sw_raw = exp_sw ^ (r[15:0] | 16'h0001);
			repeat (2) access(1'b0, 6'h02, 32'h0);
			i_sw_raw = exp_sw;
			repeat (HOLD) access(1'b0, 6'h02, 32'h0);
			// Pads are not filtered
			i_pad_in = r[31:16];
			access(1'b0, 6'h06, 32'h0);
		end
	endtask

	task automatic button_test();
		logic [31:0] r;
		pb_t         pattern;
		pb_t         mask_val;
		for (int i = 0; i < 10; i++) begin
			r = next_rand();
			pattern = (r[4:0] == '0) ? 5'h01 : r[4:0];
			mask_val = r[9:5] | (pattern & (~pattern + 5'd1));
			access(1'b1, 6'h11, {27'h0, mask_val});
			idle(1);
			check_irq();
			i_btn_raw = pattern;
			idle(HOLD);
			exp_btn = pattern;
			exp_pend = exp_pend | pattern;
			check_irq();
			access(1'b0, 6'h10, 32'h0);
			access(1'b0, 6'h12, 32'h0);
			i_btn_raw = '0;
			idle(HOLD);
			exp_btn = '0;
			access(1'b0, 6'h10, 32'h0);
			access(1'b0, 6'h12, 32'h0);
			// Partial clear and then clear the rest through an alias
			r = next_rand();
			access(1'b1, 6'h12, r);
			idle(1);
			check_irq();
			access(1'b1, 6'h1e, 32'h0000_001f);
			idle(1);
			check_irq();
			access(1'b0, 6'h12, 32'h0);
		end
	endtask

	task automatic unmapped_test();
		logic [31:0]       r;
		logic [ADDR_W-1:0] addr;
		for (int i = 0; i < 60; i++) begin
			r = next_rand();
			if (r[0]) begin
				addr = {1'b1, r[1], r[3:2], r[5:4]};
			end else begin
				addr = {1'b0, r[1], r[3:2], 2'b11};
			end
			access(r[6], addr, next_rand());
		end
		access(1'b0, 6'h00, 32'h0);
		access(1'b0, 6'h01, 32'h0);
		access(1'b0, 6'h02, 32'h0);
		access(1'b0, 6'h10, 32'h0);
		access(1'b0, 6'h11, 32'h0);
		access(1'b0, 6'h12, 32'h0);
		check_irq();
	endtask

	initial begin
		clk       = 1'b0;
		i_rst     = 1'b1;
		i_req_stb = 1'b0;
		i_req     = '0;
		i_pad_in  = '0;
		i_sw_raw  = '0;
		i_btn_raw = '0;
		errors    = 0;
		model_reset();
		repeat (8) @(posedge clk);
		#1;
		i_rst = 1'b0;
		check_reset_state();
		gpio_random_test();
		input_test();
		button_test();
		unmapped_test();
		if (errors == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- periph_core.f
+incdir+include
logic/periph_pkg.sv
logic/input_debounce.sv
logic/gpio_port.sv
logic/button_port.sv
logic/bus_decode.sv
logic/periph_core.sv
bench/tb_periph_core.sv

//--- Makefile
TOP := tb_periph_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 -f periph_core.f --top-module $(TOP) -Mdir obj_dir

# The log decides pass or fail
run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
